//--- src/bus_pkg.sv
// ##############################
// Memory bus package.
// Request and response records for the instruction memory port.
// ##############################
package bus_pkg;

    // Bus geometry.
    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 32;
    localparam int BUS_BYTES  = BUS_DATA_W / 8;

    // Byte address and data word.
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_word_t;

    // Read request, always word aligned.
    typedef struct packed {
        bus_addr_t addr;
    } imem_req_t;

    // Read response.
    // err flags an access fault on this word.
    typedef struct packed {
        bus_word_t data;
        logic      err;
    } imem_rsp_t;

endpackage

//--- src/fetch_pkg.sv
// ##############################
// Fetch package.
// Instruction types, buffer sizing and the output record.
// ##############################
package fetch_pkg;

    // Buffer capacity in words.
    localparam int FETCH_WORDS     = 2;
    // Requests in flight never exceed what the buffer can hold.
    localparam int MAX_OUTSTANDING = FETCH_WORDS;

    typedef logic [15:0] halfword_t;
    // Compressed instructions sit in the low half, upper half zero.
    typedef logic [31:0] insn_t;

    // Word count, 0 to FETCH_WORDS.
    typedef logic [$clog2(FETCH_WORDS+1)-1:0] word_cnt_t;
    // Slot index into the word queue.
    typedef logic [$clog2(FETCH_WORDS)-1:0]   word_idx_t;

    // Record handed to the core.
    typedef struct packed {
        insn_t               insn;
        bus_pkg::bus_addr_t  addr;
        logic                compressed;
        logic                fault;
        logic                mal_addr;
    } fetch_rsp_t;

    // Alignment rule for a redirect target.
    // Halfword targets are legal only with compressed support.
    function automatic logic pc_misaligned(bus_pkg::bus_addr_t pc, bit rvc);
        if (rvc) begin
            return pc[0];
        end
        return |pc[1:0];
    endfunction

endpackage

//--- src/imem_requester.sv
// ##############################
// Instruction memory requester.
// Sequential word reads under credit control.
// Drops responses issued before a redirect.
// ##############################
module imem_requester (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                redirect,
    input  bus_pkg::bus_addr_t  redirect_pc,
    input  logic                mal,
    output logic                imem_req_valid,
    input  logic                imem_req_ready,
    output bus_pkg::imem_req_t  imem_req,
    input  logic                imem_rsp_valid,
    input  bus_pkg::imem_rsp_t  imem_rsp,
    input  fetch_pkg::word_cnt_t retire_count,
    output logic                word_valid,
    output bus_pkg::imem_rsp_t  word_rsp
);
    import bus_pkg::*;
    import fetch_pkg::*;

    bus_addr_t fetch_addr;
    word_cnt_t inflight;
    word_cnt_t inflight_next;
    word_cnt_t drop_cnt;
    word_cnt_t credits;
    word_cnt_t live;
    logic      active;
    logic      req_fire;
    logic      rsp_drop;

    // Requests still owed to the current stream.
    assign live = inflight - drop_cnt;

    // Issue only with buffer room for one more word.
    // The memory side is also capped at MAX_OUTSTANDING.
    assign imem_req_valid = active && !mal && (credits > live) &&
                            (inflight < word_cnt_t'(MAX_OUTSTANDING));
    assign imem_req.addr  = fetch_addr;
    assign req_fire       = imem_req_valid && imem_req_ready;

    // Stale responses are swallowed here.
    assign rsp_drop   = imem_rsp_valid && (drop_cnt != '0);
    assign word_valid = imem_rsp_valid && (drop_cnt == '0);
    assign word_rsp   = imem_rsp;

    // Memory answers once per accepted request.
    assign inflight_next = inflight + word_cnt_t'(req_fire) - word_cnt_t'(imem_rsp_valid);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            active     <= 1'b0;
            inflight   <= '0;
            drop_cnt   <= '0;
            credits    <= word_cnt_t'(FETCH_WORDS);
            fetch_addr <= '0;
        end else begin
            inflight <= inflight_next;
            if (redirect) begin
                // Everything still in flight now belongs to the old stream.
                active     <= 1'b1;
                drop_cnt   <= inflight_next;
                credits    <= word_cnt_t'(FETCH_WORDS);
                fetch_addr <= redirect_pc & ~bus_addr_t'(BUS_BYTES - 1);
            end else begin
                // A misaligned target halts fetch until the next redirect.
                if (mal) begin
                    active <= 1'b0;
                end
                if (req_fire) begin
                    fetch_addr <= fetch_addr + bus_addr_t'(BUS_BYTES);
                end
                if (rsp_drop) begin
                    drop_cnt <= drop_cnt - word_cnt_t'(1);
                end
                // Delivered words use a credit, retired words return it.
                credits <= credits + retire_count - word_cnt_t'(word_valid);
            end
        end
    end

endmodule

//--- src/fetch_buffer.sv
// ##############################
// Fetch buffer.
// Halfword queue that realigns fetched words
// into 16- or 32-bit instructions.
// ##############################
module fetch_buffer #(
    parameter int RVC_ENABLED = 0
) (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 redirect,
    input  bus_pkg::bus_addr_t   redirect_pc,
    input  logic                 word_valid,
    input  bus_pkg::imem_rsp_t   word_rsp,
    input  logic                 take,
    output logic                 buf_valid,
    output fetch_pkg::insn_t     buf_insn,
    output bus_pkg::bus_addr_t   buf_addr,
    output logic                 buf_compressed,
    output logic                 buf_span,
    output fetch_pkg::word_cnt_t retire_count
);
    import bus_pkg::*;
    import fetch_pkg::*;

    // Word queue, slot 0 is the head.
    bus_word_t words [FETCH_WORDS];
    word_cnt_t count;
    // Halfword read offset within the head word.
    logic      offset;
    bus_addr_t pc_q;
    halfword_t head_half;
    logic      freed;
    word_idx_t fill_idx;

    assign head_half = offset ? words[0][31:16] : words[0][15:0];

    // Low bits 2'b11 mark a full-length instruction.
    assign buf_compressed = (RVC_ENABLED != 0) && (head_half[1:0] != 2'b11);
    // A 32-bit instruction in the upper half reaches into the next word.
    assign buf_span       = !buf_compressed && offset;
    assign buf_valid      = (count != '0) && (!buf_span || count >= word_cnt_t'(2));
    assign buf_addr       = pc_q;

    always_comb begin
        if (buf_compressed) begin
            buf_insn = {16'h0000, head_half};
        end else if (offset) begin
            buf_insn = {words[1][15:0], words[0][31:16]};
        end else begin
            buf_insn = words[0];
        end
    end

    // The head word is done once its upper half is consumed.
    // At most one word leaves per take.
    assign freed        = take && (!buf_compressed || offset);
    assign retire_count = word_cnt_t'(freed);

    // New word lands behind whatever survives this cycle.
    assign fill_idx = word_idx_t'(count - retire_count);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            count  <= '0;
            offset <= 1'b0;
            pc_q   <= '0;
        end else if (redirect) begin
            count  <= '0;
            offset <= (RVC_ENABLED != 0) && redirect_pc[1];
            pc_q   <= redirect_pc;
        end else begin
            count <= count - retire_count + word_cnt_t'(word_valid);
            if (take) begin
                if (buf_compressed) begin
                    pc_q   <= pc_q + bus_addr_t'(2);
                    offset <= !offset;
                end else begin
                    // Offset is unchanged, the tail half moves to slot 0.
                    pc_q <= pc_q + bus_addr_t'(4);
                end
            end
        end
    end

    // Data storage.
    // A push into slot 0 overrides the shift.
    always_ff @(posedge CLK) begin
        if (freed) begin
            words[0] <= words[1];
        end
        if (word_valid) begin
            words[fill_idx] <= word_rsp.data;
        end
    end

endmodule

//--- src/fetch_fault_check.sv
// ##############################
// Fetch fault checker.
// Misaligned redirect flag and
// per-word bus error bits.
// ##############################
module fetch_fault_check #(
    parameter int RVC_ENABLED = 0
) (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 redirect,
    input  bus_pkg::bus_addr_t   redirect_pc,
    input  logic                 word_valid,
    input  bus_pkg::imem_rsp_t   word_rsp,
    input  fetch_pkg::word_cnt_t retire_count,
    input  logic                 mal_clear,
    output logic                 mal_pending,
    output logic                 head_err,
    output logic                 next_err
);
    import fetch_pkg::*;

    // Error bits mirror the buffer's word slots.
    logic [FETCH_WORDS-1:0] errs;
    word_cnt_t              count;
    word_idx_t              fill_idx;

    assign fill_idx = word_idx_t'(count - retire_count);
    assign head_err = errs[0];
    assign next_err = errs[1];

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            count       <= '0;
            mal_pending <= 1'b0;
        end else if (redirect) begin
            count       <= '0;
            mal_pending <= pc_misaligned(redirect_pc, RVC_ENABLED != 0);
        end else begin
            count <= count - retire_count + word_cnt_t'(word_valid);
            // Cleared once the fault record is accepted.
            if (mal_clear) begin
                mal_pending <= 1'b0;
            end
        end
    end

    // Same push and shift pattern as the buffer.
    // The buffer retires at most one word per cycle.
    always_ff @(posedge CLK) begin
        if (retire_count != '0) begin
            errs[0] <= errs[1];
        end
        if (word_valid) begin
            errs[fill_idx] <= word_rsp.err;
        end
    end

endmodule

//--- src/fetch_output_stage.sv
// ##############################
// Fetch output stage.
// Merges buffer and fault results
// into one registered record.
// ##############################
module fetch_output_stage #(
    parameter int RVC_ENABLED = 0
) (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   redirect,
    input  bus_pkg::bus_addr_t     redirect_pc,
    input  logic                   buf_valid,
    input  fetch_pkg::insn_t       buf_insn,
    input  bus_pkg::bus_addr_t     buf_addr,
    input  logic                   buf_compressed,
    input  logic                   buf_span,
    input  logic                   mal_pending,
    input  logic                   head_err,
    input  logic                   next_err,
    input  logic                   insn_ready,
    output logic                   take,
    output logic                   mal_clear,
    output logic                   insn_valid,
    output fetch_pkg::fetch_rsp_t  insn
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_stream,
        st_fault_hold
    } out_state_e;

    out_state_e state;
    logic       out_valid;
    fetch_rsp_t out_rec;
    fetch_rsp_t buf_rec;
    logic       load_en;

    // Register is free when empty or being drained.
    assign load_en = !out_valid || insn_ready;
    assign take    = (state == st_stream) && !redirect && !mal_pending &&
                     buf_valid && load_en;

    // Fault record handed over, the checker may drop its flag.
    assign mal_clear = (state == st_fault_hold) && out_valid && insn_ready;

    // Spanning instructions fault on either word.
    always_comb begin
        buf_rec.insn       = buf_insn;
        buf_rec.addr       = buf_addr;
        buf_rec.compressed = buf_compressed;
        buf_rec.fault      = head_err || (buf_span && next_err);
        buf_rec.mal_addr   = 1'b0;
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state     <= st_idle;
            out_valid <= 1'b0;
        end else if (redirect) begin
            if (pc_misaligned(redirect_pc, RVC_ENABLED != 0)) begin
                // One fault record, then halt.
                state     <= st_fault_hold;
                out_valid <= 1'b1;
            end else begin
                state     <= st_stream;
                out_valid <= 1'b0;
            end
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (insn_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Record payload.
    always_ff @(posedge CLK) begin
        if (redirect) begin
            out_rec.insn       <= '0;
            out_rec.addr       <= redirect_pc;
            out_rec.compressed <= 1'b0;
            out_rec.fault      <= 1'b0;
            out_rec.mal_addr   <= 1'b1;
        end else if (take) begin
            out_rec <= buf_rec;
        end
    end

    assign insn_valid = out_valid;
    assign insn       = out_rec;

endmodule

//--- src/fetch_unit.sv
// ##############################
// Fetch unit top.
// Requester, buffer, fault checker
// and output stage.
// ##############################
module fetch_unit #(
    parameter int RVC_ENABLED = 0
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  redirect,
    input  bus_pkg::bus_addr_t    redirect_pc,
    output logic                  imem_req_valid,
    input  logic                  imem_req_ready,
    output bus_pkg::imem_req_t    imem_req,
    input  logic                  imem_rsp_valid,
    input  bus_pkg::imem_rsp_t    imem_rsp,
    output logic                  insn_valid,
    input  logic                  insn_ready,
    output fetch_pkg::fetch_rsp_t insn
);
    import bus_pkg::*;
    import fetch_pkg::*;

    // Current words from the requester.
    logic      word_valid;
    imem_rsp_t word_rsp;
    // Words freed by the buffer this cycle.
    word_cnt_t retire_count;
    // Buffer head offer.
    logic      buf_valid;
    insn_t     buf_insn;
    bus_addr_t buf_addr;
    logic      buf_compressed;
    logic      buf_span;
    logic      take;
    // Fault side.
    logic      mal_pending;
    logic      mal_clear;
    logic      head_err;
    logic      next_err;

    imem_requester i_requester (
        .CLK,
        .rst_n,
        .redirect,
        .redirect_pc,
        .mal (mal_pending),
        .imem_req_valid,
        .imem_req_ready,
        .imem_req,
        .imem_rsp_valid,
        .imem_rsp,
        .retire_count,
        .word_valid,
        .word_rsp
    );

    fetch_buffer #(.RVC_ENABLED(RVC_ENABLED)) i_buffer (
        .CLK,
        .rst_n,
        .redirect,
        .redirect_pc,
        .word_valid,
        .word_rsp,
        .take,
        .buf_valid,
        .buf_insn,
        .buf_addr,
        .buf_compressed,
        .buf_span,
        .retire_count
    );

    fetch_fault_check #(.RVC_ENABLED(RVC_ENABLED)) i_fault_check (
        .CLK,
        .rst_n,
        .redirect,
        .redirect_pc,
        .word_valid,
        .word_rsp,
        .retire_count,
        .mal_clear,
        .mal_pending,
        .head_err,
        .next_err
    );

    fetch_output_stage #(.RVC_ENABLED(RVC_ENABLED)) i_output_stage (
        .CLK,
        .rst_n,
        .redirect,
        .redirect_pc,
        .buf_valid,
        .buf_insn,
        .buf_addr,
        .buf_compressed,
        .buf_span,
        .mal_pending,
        .head_err,
        .next_err,
        .insn_ready,
        .take,
        .mal_clear,
        .insn_valid,
        .insn
    );

endmodule

//--- tests/tb_imem_model.sv
// ##############################
// Instruction memory model.
// In-order reads with random ready and latency.
// Words at or above ERR_BASE answer with err.
// ##############################
module tb_imem_model #(
    parameter bus_pkg::bus_addr_t ERR_BASE = 32'h0000_0600
) (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               req_valid,
    output logic               req_ready,
    input  bus_pkg::imem_req_t req,
    output logic               rsp_valid,
    output bus_pkg::imem_rsp_t rsp,
    output int                 inflight
);
    timeunit 1ns;
    timeprecision 1ps;
    import bus_pkg::*;

    // Word array, filled by the tests.
    bus_word_t mem [1024];
    integer    seed;
    int        cyc;
    int        lat;
    int        due;
    int        last_due;
    // Accepted requests waiting for their answer, oldest first.
    int        due_q[$];
    bus_addr_t addr_q[$];

    initial begin
        seed      = 32'h5273_4f30;
        cyc       = 0;
        last_due  = 0;
        inflight  = 0;
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp       = '0;
        // Background pattern, different for every word.
        for (int i = 0; i < 1024; i++) begin
            mem[i] = bus_word_t'(i) * 32'h9e37_79b9;
        end
    end

    // Accept requests and retire answers at the rising edge.
    always @(posedge CLK) begin
        cyc = cyc + 1;
        if (!rst_n) begin
            due_q.delete();
            addr_q.delete();
        end else begin
            if (rsp_valid) begin
                void'(due_q.pop_front());
                void'(addr_q.pop_front());
            end
            if (req_valid && req_ready) begin
                lat = 1 + int'($unsigned($random(seed)) % 4);
                due = cyc + lat;
                // Answers stay in order.
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                due_q.push_back(due);
                addr_q.push_back(req.addr);
            end
        end
        inflight = due_q.size();
    end

    // Outputs change on the falling edge.
    always @(negedge CLK) begin
        req_ready = rst_n && 1'($random(seed));
        if (due_q.size() > 0 && due_q[0] <= cyc + 1) begin
            rsp_valid = 1'b1;
            rsp.data  = mem[addr_q[0][11:2]];
            rsp.err   = addr_q[0] >= ERR_BASE;
        end else begin
            rsp_valid = 1'b0;
        end
    end

endmodule

//--- tests/tb_fetch_unit.sv
// ##############################
// Fetch unit testbench.
// Directed tests against a reference walk of memory.
// ##############################
module tb_fetch_unit #(
    parameter int RVC_ENABLED = 0
);
    timeunit 1ns;
    timeprecision 1ps;
    import bus_pkg::*;
    import fetch_pkg::*;

    localparam bus_addr_t ERR_BASE    = 32'h0000_0600;
    // Records expected per test, summed over all tests.
    localparam int        TOTAL_INSNS = 16 + (4 + 12) + ((RVC_ENABLED != 0) ? 1 + 8 : 2) +
                                        12 + 16;
    localparam int        CYCLE_LIMIT = 40 * TOTAL_INSNS;

    logic       CLK;
    logic       rst_n;
    logic       redirect;
    bus_addr_t  redirect_pc;
    logic       imem_req_valid;
    logic       imem_req_ready;
    imem_req_t  imem_req;
    logic       imem_rsp_valid;
    imem_rsp_t  imem_rsp;
    logic       insn_valid;
    logic       insn_ready;
    fetch_rsp_t insn;

    integer     seed;
    int         cycles = 0;
    int         mem_inflight;
    logic       bp_mode;
    // Records accepted since the last redirect.
    fetch_rsp_t rec_q[$];

    fetch_unit #(.RVC_ENABLED(RVC_ENABLED)) i_dut (.*);

    tb_imem_model #(.ERR_BASE(ERR_BASE)) i_mem (
        .CLK,
        .rst_n,
        .req_valid (imem_req_valid),
        .req_ready (imem_req_ready),
        .req       (imem_req),
        .rsp_valid (imem_rsp_valid),
        .rsp       (imem_rsp),
        .inflight  (mem_inflight)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "check mismatch");
        end
    endtask

    // A record taken in the redirect cycle belongs to the old stream.
    always @(posedge CLK) begin
        if (rst_n && !redirect && insn_valid && insn_ready) begin
            rec_q.push_back(insn);
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    // Core ready and the in-flight limit.
    always @(negedge CLK) begin
        if (bp_mode) begin
            insn_ready <= 1'($random(seed));
        end else begin
            insn_ready <= 1'b1;
        end
        check_value(32'(mem_inflight <= FETCH_WORDS), 32'd1, "requests in flight");
    end

    function automatic halfword_t half_at(bus_addr_t a);
        bus_word_t w;
        w = i_mem.mem[a[11:2]];
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    function automatic logic err_at(bus_addr_t a);
        return a >= ERR_BASE;
    endfunction

    task automatic load_code(input bus_addr_t base, input int nwords);
        for (int i = 0; i < nwords; i++) begin
            i_mem.mem[base[11:2] + 10'(i)] = $random(seed);
        end
    endtask

    // Redirect pulse launched from a falling edge.
    task automatic pulse_redirect(input bus_addr_t pc);
        rec_q.delete();
        redirect    = 1'b1;
        redirect_pc = pc;
        @(negedge CLK);
        redirect = 1'b0;
    endtask

    task automatic do_redirect(input bus_addr_t pc);
        @(negedge CLK);
        pulse_redirect(pc);
    endtask

    task automatic wait_records(input int n);
        while (rec_q.size() < n) begin
            @(posedge CLK);
        end
    endtask

    // Walk memory from pc and compare the first n records.
    task automatic expect_stream(input bus_addr_t pc, input int n);
        bus_addr_t  a;
        halfword_t  lo;
        fetch_rsp_t exp_rec;
        wait_records(n);
        a = pc;
        for (int i = 0; i < n; i++) begin
            lo               = half_at(a);
            exp_rec.mal_addr = 1'b0;
            exp_rec.addr     = a;
            if (RVC_ENABLED != 0 && lo[1:0] != 2'b11) begin
                exp_rec.insn       = {16'h0000, lo};
                exp_rec.compressed = 1'b1;
                exp_rec.fault      = err_at(a);
                a                  = a + 32'd2;
            end else begin
                exp_rec.insn       = {half_at(a + 32'd2), lo};
                exp_rec.compressed = 1'b0;
                exp_rec.fault      = err_at(a) || err_at(a + 32'd2);
                a                  = a + 32'd4;
            end
            check_value(rec_q[i].addr, exp_rec.addr, "record addr");
            check_value(rec_q[i].insn, exp_rec.insn, "record insn");
            check_value(32'(rec_q[i].compressed), 32'(exp_rec.compressed), "compressed");
            check_value(32'(rec_q[i].fault), 32'(exp_rec.fault), "fault");
            check_value(32'(rec_q[i].mal_addr), 32'd0, "mal_addr");
        end
    endtask

    // One fault record and no requests or records after it.
    task automatic expect_misaligned(input bus_addr_t pc);
        do_redirect(pc);
        wait_records(1);
        check_value(32'(rec_q[0].mal_addr), 32'd1, "mal_addr on misaligned pc");
        check_value(rec_q[0].addr, pc, "misaligned record addr");
        check_value(rec_q[0].insn, 32'd0, "misaligned record insn");
        repeat (20) begin
            @(negedge CLK);
            check_value(32'(imem_req_valid), 32'd0, "request after misaligned redirect");
        end
        check_value(32'(rec_q.size()), 32'd1, "records after misaligned fault");
    endtask

    task automatic test_sequential();
        load_code(32'h0000_0000, 24);
        do_redirect(32'h0000_0000);
        expect_stream(32'h0000_0000, 16);
    endtask

    task automatic test_redirect_midstream();
        bus_addr_t b_pc;
        b_pc = (RVC_ENABLED != 0) ? 32'h0000_0402 : 32'h0000_0400;
        load_code(32'h0000_0100, 16);
        load_code(32'h0000_0400, 16);
        do_redirect(32'h0000_0100);
        expect_stream(32'h0000_0100, 4);
        // Both request slots wait for answers when the redirect lands.
        @(negedge CLK);
        while (mem_inflight < FETCH_WORDS) begin
            @(negedge CLK);
        end
        pulse_redirect(b_pc);
        expect_stream(b_pc, 12);
    endtask

    task automatic test_misaligned();
        load_code(32'h0000_0200, 16);
        expect_misaligned(32'h0000_0201);
        if (RVC_ENABLED != 0) begin
            do_redirect(32'h0000_0202);
            expect_stream(32'h0000_0202, 8);
        end else begin
            expect_misaligned(32'h0000_0202);
        end
    endtask

    // Stream runs across ERR_BASE.
    // Full-length words lead up to the edge.
    // Word 0x5fc holds a compressed halfword and then a 32-bit instruction
    // that reaches into the error region.
    task automatic test_bus_error();
        load_code(32'h0000_05e0, 16);
        for (int i = 0; i < 3; i++) begin
            i_mem.mem[10'h17c + 10'(i)] = i_mem.mem[10'h17c + 10'(i)] | 32'h0000_0003;
        end
        i_mem.mem[10'h17f] = (i_mem.mem[10'h17f] & 32'hfffc_fffc) | 32'h0003_0001;
        do_redirect(32'h0000_05f0);
        expect_stream(32'h0000_05f0, 12);
    endtask

    task automatic test_backpressure();
        load_code(32'h0000_0700, 24);
        bp_mode = 1'b1;
        do_redirect(32'h0000_0700);
        expect_stream(32'h0000_0700, 16);
        bp_mode = 1'b0;
    endtask

    initial begin
        seed        = 32'h5273_4f30;
        rst_n       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        insn_ready  = 1'b0;
        bp_mode     = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        test_sequential();
        test_redirect_midstream();
        test_misaligned();
        test_bus_error();
        test_backpressure();
        $display("sim passed");
        $finish;
    end

endmodule

//--- sources.f
src/bus_pkg.sv
src/fetch_pkg.sv
src/imem_requester.sv
src/fetch_buffer.sv
src/fetch_fault_check.sv
src/fetch_output_stage.sv
src/fetch_unit.sv
tests/tb_imem_model.sv
tests/tb_fetch_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench for both RVC_ENABLED values.
cd "$(dirname "$0")" &&
verilator --binary -f sources.f --top-module tb_fetch_unit -GRVC_ENABLED=0 \
    --Mdir obj_rvc0 -o sim &&
./obj_rvc0/sim &&
verilator --binary -f sources.f --top-module tb_fetch_unit -GRVC_ENABLED=1 \
    --Mdir obj_rvc1 -o sim &&
./obj_rvc1/sim || exit 1
